// ==== list.f ====
src/kernel_ctrl_pkg.sv
src/reset_extender.sv
src/axi_lite_regs.sv
src/cmd_launcher.sv
src/watchdog_timer.sv
src/kernel_ctrl_top.sv
tests/tb_kernel_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# Exit status is nonzero when the build fails or the simulation ends in $fatal.

cd "$(dirname "$0")" &&
verilator --binary --timing -f list.f --top-module tb_kernel_ctrl -o sim_kernel_ctrl &&
./obj_dir/sim_kernel_ctrl ||
{
  echo "Simulation did not pass"
  exit 1
}

// ==== tests/tb_kernel_ctrl.sv ====
`default_nettype none

module tb_kernel_ctrl;

  // Bus traffic, two watchdog periods per hold-off test, plus margin
  localparam int unsigned TIMEOUT_CYCLES = 6000;
  localparam int          STALL_LIMIT    = 64;

  logic                         clk;
  logic                         rstn;
  logic                         button_i;
  kernel_ctrl_pkg::axil_req_t   bus_req;
  kernel_ctrl_pkg::axil_rsp_t   bus_rsp;
  kernel_ctrl_pkg::core_state_t core_state;
  kernel_ctrl_pkg::launch_t     launch;
  logic                         sys_reset;
  logic                         core_rstn;

  logic [15:0]            lfsr_q = 16'd36538;
  int unsigned            cycle = 0;
  int unsigned            b_rise_cycle;
  int                     launches_expected = 0;
  int                     launches_seen = 0;
  kernel_ctrl_pkg::word_t shadow [kernel_ctrl_pkg::REG_NUM];

  kernel_ctrl_top u_dut (
    .clk          (clk),
    .rstn         (rstn),
    .bus_req_i    (bus_req),
    .bus_rsp_o    (bus_rsp),
    .core_state_i (core_state),
    .button_i     (button_i),
    .launch_o     (launch),
    .sys_reset_o  (sys_reset),
    .core_rstn_o  (core_rstn)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Random data and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic kernel_ctrl_pkg::word_t rand_bits(input int n);
    kernel_ctrl_pkg::word_t v;
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic kernel_ctrl_pkg::word_t reg_addr(input int idx);
    return kernel_ctrl_pkg::word_t'(idx) << kernel_ctrl_pkg::REG_IDX_LO;
  endfunction

  // Read map: word 0 from the register, 1 to 4 from core state, rest zero
  function automatic kernel_ctrl_pkg::word_t expected_read(input int idx);
    case (idx)
      0: return shadow[0];
      1: return core_state.state0;
      2: return core_state.state1;
      3: return core_state.state2;
      4: return core_state.state3;
      default: return '0;
    endcase
  endfunction

  // Launch lands D+1 cycles after the response rises
  function automatic int unsigned expected_launch_lag(input kernel_ctrl_pkg::word_t delay);
    return delay + 32'd1;
  endfunction

  // Enable takes effect as bvalid rises, output register adds one
  function automatic int unsigned expected_wdog_lag();
    return kernel_ctrl_pkg::WDOG_PERIOD_CYCLES + 1;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input kernel_ctrl_pkg::word_t expected,
                             input kernel_ctrl_pkg::word_t actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      abort_run("Value mismatch");
    end
  endtask

  task automatic tick_or_stall(inout int n, input int limit, input string what);
    @(negedge clk);
    n++;
    if (n > limit) begin
      abort_run($sformatf("Stalled: %s", what));
    end
  endtask

  task automatic expect_switch_low(input int cycles, input string name);
    repeat (cycles) begin
      @(negedge clk);
      check_value(name, '0, kernel_ctrl_pkg::word_t'(sys_reset));
    end
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  // Launch monitor
  always @(negedge clk) begin
    if (launch.valid === 1'b1) begin
      if (launches_seen >= launches_expected) begin
        abort_run("A launch strobe appeared with no command pending");
      end else begin
        check_value("launch cycle",
                    b_rise_cycle + expected_launch_lag(shadow[4]), cycle);
        check_value("launch command", shadow[1], launch.command);
        check_value("launch data0", shadow[2], launch.data0);
        check_value("launch data1", shadow[3], launch.data1);
        launches_seen = launches_seen + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AXI-lite master
  //////////////////////////////////////////////////////////////////////

  task automatic bus_write(input int idx, input kernel_ctrl_pkg::word_t data);
    int n;
    int hold;
    hold = int'(rand_bits(2));
    @(posedge clk);
    bus_req.awaddr  <= reg_addr(idx);
    bus_req.awvalid <= 1'b1;
    bus_req.wdata   <= data;
    bus_req.wvalid  <= 1'b1;
    n = 0;
    do tick_or_stall(n, STALL_LIMIT, "write address and data not accepted");
    while (!(bus_rsp.awready && bus_rsp.wready));
    @(posedge clk);
    bus_req.awvalid <= 1'b0;
    bus_req.wvalid  <= 1'b0;
    n = 0;
    do tick_or_stall(n, STALL_LIMIT, "no write response");
    while (!bus_rsp.bvalid);
    b_rise_cycle = cycle;
    // Back-pressure on the response
    repeat (hold) begin
      @(posedge clk);
      @(negedge clk);
      if (!bus_rsp.bvalid) begin
        abort_run("bvalid dropped while bready was low");
      end
    end
    @(posedge clk);
    bus_req.bready <= 1'b1;
    @(posedge clk);
    bus_req.bready <= 1'b0;
    if (idx <= 4) begin
      shadow[idx] = data;
    end
  endtask

  task automatic bus_read(input int idx, output kernel_ctrl_pkg::word_t data);
    int n;
    int hold;
    hold = int'(rand_bits(2));
    @(posedge clk);
    bus_req.araddr  <= reg_addr(idx);
    bus_req.arvalid <= 1'b1;
    n = 0;
    do tick_or_stall(n, STALL_LIMIT, "read address not accepted");
    while (!bus_rsp.arready);
    @(posedge clk);
    bus_req.arvalid <= 1'b0;
    n = 0;
    do tick_or_stall(n, STALL_LIMIT, "no read response");
    while (!bus_rsp.rvalid);
    repeat (hold) begin
      @(posedge clk);
      @(negedge clk);
      if (!bus_rsp.rvalid) begin
        abort_run("rvalid dropped while rready was low");
      end
    end
    data = bus_rsp.rdata;
    @(posedge clk);
    bus_req.rready <= 1'b1;
    @(posedge clk);
    bus_req.rready <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    kernel_ctrl_pkg::word_t rd;
    kernel_ctrl_pkg::word_t d;
    int n;
    int unsigned lag;
    clk        = 1'b0;
    rstn       = 1'b0;
    button_i   = 1'b0;
    bus_req    = '0;
    core_state = '0;
    for (n = 0; n < kernel_ctrl_pkg::REG_NUM; n++) begin
      shadow[n] = '0;
    end
    shadow[0] = kernel_ctrl_pkg::KERNEL_ARG_RESET;

    repeat (16) @(posedge clk);
    rstn <= 1'b1;

    // Reset extension and idle bus state
    n = 0;
    @(negedge clk);
    while (!core_rstn) begin
      tick_or_stall(n, 100, "internal reset never released");
    end
    check_value("reset stretch", kernel_ctrl_pkg::RESET_EXTEND_CYCLES, n);
    check_value("idle handshake lines", 32'b11010, kernel_ctrl_pkg::word_t'({bus_rsp.awready,
                bus_rsp.wready, bus_rsp.bvalid, bus_rsp.arready, bus_rsp.rvalid}));
    bus_read(0, rd);
    check_value("reset value of register 0", expected_read(0), rd);

    // Register readback; delay kept huge so the register 0 write never fires
    @(posedge clk);
    core_state <= {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    bus_write(1, rand_bits(32));
    bus_write(2, rand_bits(32));
    bus_write(3, rand_bits(32));
    bus_write(4, rand_bits(32) | 32'h8000_0000);
    // Clear goes high before enable so the watchdog stays quiet
    bus_write(5, 32'hFFFF_FFFF);
    bus_write(6, 32'hFFFF_FFFF);
    bus_write(7, rand_bits(32));
    bus_write(0, rand_bits(32));
    for (n = 0; n < kernel_ctrl_pkg::REG_NUM; n++) begin
      bus_read(n, rd);
      check_value($sformatf("readback of index %0d", n), expected_read(n), rd);
    end
    bus_write(6, '0);
    bus_write(5, '0);

    // Delayed command launch
    repeat (3) begin
      d = rand_bits(5);
      if (d > 32'd30) begin
        d = 32'd30;
      end
      bus_write(1, rand_bits(32));
      bus_write(2, rand_bits(32));
      bus_write(3, rand_bits(32));
      bus_write(4, d);
      launches_expected = launches_expected + 1;
      bus_write(0, rand_bits(32));
      n = 0;
      while (launches_seen < launches_expected) begin
        tick_or_stall(n, STALL_LIMIT, "launch strobe never arrived");
      end
    end

    // Watchdog timeout and pulse length
    bus_write(6, 32'd1);
    n = 0;
    while (!sys_reset) begin
      tick_or_stall(n, kernel_ctrl_pkg::WDOG_PERIOD_CYCLES + 40, "watchdog never fired");
    end
    lag = cycle - b_rise_cycle;
    if (lag < expected_wdog_lag() || lag > expected_wdog_lag() + 1) begin
      check_value("watchdog lead-in", expected_wdog_lag(), lag);
    end
    n = 0;
    while (sys_reset) begin
      n++;
      @(negedge clk);
      if (n > 100) begin
        abort_run("Watchdog switch stuck high");
      end
    end
    check_value("watchdog hold", kernel_ctrl_pkg::WDOG_HOLD_CYCLES, n);

    // Held off by clear, then by disable
    bus_write(5, 32'd1);
    expect_switch_low(2 * kernel_ctrl_pkg::WDOG_PERIOD_CYCLES, "switch with clear high");
    bus_write(6, '0);
    bus_write(5, '0);
    expect_switch_low(2 * kernel_ctrl_pkg::WDOG_PERIOD_CYCLES, "switch with enable low");

    // Push button
    @(posedge clk);
    button_i <= 1'b1;
    @(negedge clk);
    check_value("switch in button cycle", '0, kernel_ctrl_pkg::word_t'(sys_reset));
    repeat (4) begin
      @(negedge clk);
      check_value("switch with button held", 32'd1, kernel_ctrl_pkg::word_t'(sys_reset));
    end
    @(posedge clk);
    button_i <= 1'b0;
    @(negedge clk);
    check_value("switch in release cycle", 32'd1, kernel_ctrl_pkg::word_t'(sys_reset));
    @(negedge clk);
    check_value("switch after release", '0, kernel_ctrl_pkg::word_t'(sys_reset));

    // Quiet window for stray launches
    repeat (40) @(negedge clk);
    if (launches_seen != launches_expected) begin
      abort_run("Launch count differs from the commands issued");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== src/kernel_ctrl_top.sv ====
`default_nettype none

module kernel_ctrl_top (
  input  logic                          clk,
  input  logic                          rstn,
  input  kernel_ctrl_pkg::axil_req_t    bus_req_i,
  output kernel_ctrl_pkg::axil_rsp_t    bus_rsp_o,
  input  kernel_ctrl_pkg::core_state_t  core_state_i,
  input  logic                          button_i,
  output kernel_ctrl_pkg::launch_t      launch_o,
  output logic                          sys_reset_o,
  output logic                          core_rstn_o
);

  logic                   core_rstn;
  logic                   cmd_new;
  kernel_ctrl_pkg::word_t command;
  kernel_ctrl_pkg::word_t data0;
  kernel_ctrl_pkg::word_t data1;
  kernel_ctrl_pkg::word_t delay;
  logic                   wdog_enable;
  logic                   wdog_clear;

  //////////////////////////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////////////////////////

  // Only the extender sees the external reset
  reset_extender u_reset_extender (
    .clk         (clk),
    .rstn        (rstn),
    .rst_ext_n_o (core_rstn)
  );

  assign core_rstn_o = core_rstn;

  //////////////////////////////////////////////////////////////////////
  // Register slave and its consumers
  //////////////////////////////////////////////////////////////////////

  axi_lite_regs u_axi_lite_regs (
    .clk           (clk),
    .rstn          (core_rstn),
    .bus_req_i     (bus_req_i),
    .bus_rsp_o     (bus_rsp_o),
    .core_state_i  (core_state_i),
    .cmd_new_o     (cmd_new),
    .command_o     (command),
    .data0_o       (data0),
    .data1_o       (data1),
    .delay_o       (delay),
    .wdog_enable_o (wdog_enable),
    .wdog_clear_o  (wdog_clear)
  );

  cmd_launcher u_cmd_launcher (
    .clk       (clk),
    .rstn      (core_rstn),
    .cmd_new_i (cmd_new),
    .command_i (command),
    .data0_i   (data0),
    .data1_i   (data1),
    .delay_i   (delay),
    .launch_o  (launch_o)
  );

  watchdog_timer u_watchdog_timer (
    .clk         (clk),
    .rstn        (core_rstn),
    .enable_i    (wdog_enable),
    .clear_i     (wdog_clear),
    .button_i    (button_i),
    .sys_reset_o (sys_reset_o)
  );

endmodule

`default_nettype wire

// ==== src/watchdog_timer.sv ====
`default_nettype none

module watchdog_timer (
  input  logic clk,
  input  logic rstn,
  input  logic enable_i,
  input  logic clear_i,
  input  logic button_i,
  output logic sys_reset_o
);

  logic [kernel_ctrl_pkg::WDOG_CNT_W-1:0] period_q;
  logic [kernel_ctrl_pkg::HOLD_CNT_W-1:0] hold_q;

  logic pulse;
  logic running;
  logic expired;

  assign pulse   = (hold_q != '0);
  // Period counter sits at zero while the pulse is out
  assign running = enable_i && !clear_i && !pulse;
  assign expired = running &&
    (period_q == kernel_ctrl_pkg::WDOG_CNT_W'(kernel_ctrl_pkg::WDOG_PERIOD_CYCLES - 1));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      period_q    <= '0;
      hold_q      <= '0;
      sys_reset_o <= 1'b0;
    end else begin
      if (!running || expired) begin
        period_q <= '0;
      end else begin
        period_q <= period_q + kernel_ctrl_pkg::WDOG_CNT_W'(1);
      end

      if (expired) begin
        hold_q <= kernel_ctrl_pkg::HOLD_CNT_W'(kernel_ctrl_pkg::WDOG_HOLD_CYCLES);
      end else if (pulse) begin
        hold_q <= hold_q - kernel_ctrl_pkg::HOLD_CNT_W'(1);
      end

      // Push button shares the switch
      sys_reset_o <= pulse | button_i;
    end
  end

endmodule

`default_nettype wire

// ==== src/cmd_launcher.sv ====
`default_nettype none

module cmd_launcher (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    cmd_new_i,
  input  kernel_ctrl_pkg::word_t  command_i,
  input  kernel_ctrl_pkg::word_t  data0_i,
  input  kernel_ctrl_pkg::word_t  data1_i,
  input  kernel_ctrl_pkg::word_t  delay_i,
  output kernel_ctrl_pkg::launch_t launch_o
);

  logic                   active_q;
  kernel_ctrl_pkg::word_t count_q;
  logic                   fire;

  // Counter reaching zero while armed is the launch cycle
  assign fire = active_q && (count_q == '0);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      active_q <= 1'b0;
      count_q  <= '0;
    end else if (cmd_new_i) begin
      // A new command restarts any countdown in flight
      active_q <= 1'b1;
      count_q  <= delay_i;
    end else if (active_q) begin
      if (fire) begin
        active_q <= 1'b0;
      end else begin
        count_q <= count_q - kernel_ctrl_pkg::word_t'(1);
      end
    end
  end

  // Fields follow the registers, only valid is timed
  assign launch_o.valid   = fire;
  assign launch_o.command = command_i;
  assign launch_o.data0   = data0_i;
  assign launch_o.data1   = data1_i;

endmodule

`default_nettype wire

// ==== src/axi_lite_regs.sv ====
`default_nettype none

module axi_lite_regs (
  input  logic                          clk,
  input  logic                          rstn,
  input  kernel_ctrl_pkg::axil_req_t    bus_req_i,
  output kernel_ctrl_pkg::axil_rsp_t    bus_rsp_o,
  input  kernel_ctrl_pkg::core_state_t  core_state_i,
  output logic                          cmd_new_o,
  output kernel_ctrl_pkg::word_t        command_o,
  output kernel_ctrl_pkg::word_t        data0_o,
  output kernel_ctrl_pkg::word_t        data1_o,
  output kernel_ctrl_pkg::word_t        delay_o,
  output logic                          wdog_enable_o,
  output logic                          wdog_clear_o
);

  // Channel state
  logic aw_ready_q;
  logic w_ready_q;
  logic aw_got_q;
  logic w_got_q;
  logic b_valid_q;
  logic ar_ready_q;
  logic r_valid_q;
  logic cmd_new_q;

  // Latched beats and read data
  kernel_ctrl_pkg::reg_idx_e wr_idx_q;
  kernel_ctrl_pkg::word_t    wr_data_q;
  kernel_ctrl_pkg::word_t    rd_data_q;

  // Register file
  kernel_ctrl_pkg::word_t kernel_arg_q;
  kernel_ctrl_pkg::word_t command_q;
  kernel_ctrl_pkg::word_t data0_q;
  kernel_ctrl_pkg::word_t data1_q;
  kernel_ctrl_pkg::word_t delay_q;
  logic                   wdog_clear_q;
  logic                   wdog_enable_q;

  kernel_ctrl_pkg::reg_idx_e aw_idx;
  kernel_ctrl_pkg::reg_idx_e ar_idx;
  kernel_ctrl_pkg::word_t    rd_word;

  logic aw_hs;
  logic w_hs;
  logic b_hs;
  logic ar_hs;
  logic r_hs;
  logic commit;

  assign aw_idx = kernel_ctrl_pkg::reg_idx_e'(
    bus_req_i.awaddr[kernel_ctrl_pkg::REG_IDX_LO +: kernel_ctrl_pkg::REG_IDX_W]);
  assign ar_idx = kernel_ctrl_pkg::reg_idx_e'(
    bus_req_i.araddr[kernel_ctrl_pkg::REG_IDX_LO +: kernel_ctrl_pkg::REG_IDX_W]);

  assign aw_hs  = aw_ready_q && bus_req_i.awvalid;
  assign w_hs   = w_ready_q && bus_req_i.wvalid;
  assign b_hs   = b_valid_q && bus_req_i.bready;
  assign ar_hs  = ar_ready_q && bus_req_i.arvalid;
  assign r_hs   = r_valid_q && bus_req_i.rready;
  assign commit = aw_got_q && w_got_q;

  //////////////////////////////////////////////////////////////////////
  // Write channels
  //////////////////////////////////////////////////////////////////////

  // AW and W are taken independently, the write commits when both are in
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_ready_q <= 1'b1;
      w_ready_q  <= 1'b1;
      aw_got_q   <= 1'b0;
      w_got_q    <= 1'b0;
      b_valid_q  <= 1'b0;
      cmd_new_q  <= 1'b0;
    end else begin
      cmd_new_q <= 1'b0;
      if (aw_hs) begin
        aw_ready_q <= 1'b0;
        aw_got_q   <= 1'b1;
      end
      if (w_hs) begin
        w_ready_q <= 1'b0;
        w_got_q   <= 1'b1;
      end
      if (commit) begin
        aw_got_q  <= 1'b0;
        w_got_q   <= 1'b0;
        b_valid_q <= 1'b1;
        cmd_new_q <= (wr_idx_q == kernel_ctrl_pkg::REG_KERNEL_ARG);
      end
      // Both ready lines come back only after the response is taken
      if (b_hs) begin
        b_valid_q  <= 1'b0;
        aw_ready_q <= 1'b1;
        w_ready_q  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_idx_q <= aw_idx;
    end
    if (w_hs) begin
      wr_data_q <= bus_req_i.wdata;
    end
    if (ar_hs) begin
      rd_data_q <= rd_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      kernel_arg_q  <= kernel_ctrl_pkg::KERNEL_ARG_RESET;
      command_q     <= '0;
      data0_q       <= '0;
      data1_q       <= '0;
      delay_q       <= '0;
      wdog_clear_q  <= 1'b0;
      wdog_enable_q <= 1'b0;
    end else if (commit) begin
      case (wr_idx_q)
        kernel_ctrl_pkg::REG_KERNEL_ARG:  kernel_arg_q  <= wr_data_q;
        kernel_ctrl_pkg::REG_COMMAND:     command_q     <= wr_data_q;
        kernel_ctrl_pkg::REG_DATA0:       data0_q       <= wr_data_q;
        kernel_ctrl_pkg::REG_DATA1:       data1_q       <= wr_data_q;
        kernel_ctrl_pkg::REG_DELAY:       delay_q       <= wr_data_q;
        kernel_ctrl_pkg::REG_WDOG_CLEAR:  wdog_clear_q  <= wr_data_q[0];
        kernel_ctrl_pkg::REG_WDOG_ENABLE: wdog_enable_q <= wr_data_q[0];
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////////////////////////

  // Indexes 1 to 4 read back core state, not the written command words
  always_comb begin
    case (ar_idx)
      kernel_ctrl_pkg::REG_KERNEL_ARG: rd_word = kernel_arg_q;
      kernel_ctrl_pkg::REG_COMMAND:    rd_word = core_state_i.state0;
      kernel_ctrl_pkg::REG_DATA0:      rd_word = core_state_i.state1;
      kernel_ctrl_pkg::REG_DATA1:      rd_word = core_state_i.state2;
      kernel_ctrl_pkg::REG_DELAY:      rd_word = core_state_i.state3;
      default:                         rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ar_ready_q <= 1'b1;
      r_valid_q  <= 1'b0;
    end else begin
      if (ar_hs) begin
        ar_ready_q <= 1'b0;
        r_valid_q  <= 1'b1;
      end
      if (r_hs) begin
        r_valid_q  <= 1'b0;
        ar_ready_q <= 1'b1;
      end
    end
  end

  assign bus_rsp_o.awready = aw_ready_q;
  assign bus_rsp_o.wready  = w_ready_q;
  assign bus_rsp_o.bvalid  = b_valid_q;
  assign bus_rsp_o.arready = ar_ready_q;
  assign bus_rsp_o.rvalid  = r_valid_q;
  assign bus_rsp_o.rdata   = rd_data_q;

  assign cmd_new_o     = cmd_new_q;
  assign command_o     = command_q;
  assign data0_o       = data0_q;
  assign data1_o       = data1_q;
  assign delay_o       = delay_q;
  assign wdog_enable_o = wdog_enable_q;
  assign wdog_clear_o  = wdog_clear_q;

endmodule

`default_nettype wire

// ==== src/reset_extender.sv ====
`default_nettype none

module reset_extender (
  input  logic clk,
  input  logic rstn,
  output logic rst_ext_n_o
);

  logic [kernel_ctrl_pkg::RST_CNT_W-1:0] count_q;

  // Counter reloads while rstn is low and runs down once it is released.
  // The output flips high on the edge where the counter hits zero.
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      count_q     <= kernel_ctrl_pkg::RST_CNT_W'(kernel_ctrl_pkg::RESET_EXTEND_CYCLES);
      rst_ext_n_o <= 1'b0;
    end else if (count_q != '0) begin
      count_q     <= count_q - kernel_ctrl_pkg::RST_CNT_W'(1);
      rst_ext_n_o <= (count_q == kernel_ctrl_pkg::RST_CNT_W'(1));
    end
  end

endmodule

`default_nettype wire

// ==== src/kernel_ctrl_pkg.sv ====
`default_nettype none

package kernel_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register map geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned WORD_W     = 32;
  localparam int unsigned REG_NUM    = 8;
  localparam int unsigned REG_IDX_W  = $clog2(REG_NUM);
  localparam int unsigned REG_IDX_LO = 2;

  localparam logic [WORD_W-1:0] KERNEL_ARG_RESET = 32'hDEAD_BEEF;

  //////////////////////////////////////////////////////////////////////
  // Timer constants, scaled down for simulation
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned RESET_EXTEND_CYCLES = 32;
  localparam int unsigned WDOG_PERIOD_CYCLES  = 400;
  localparam int unsigned WDOG_HOLD_CYCLES    = 20;

  // Counter widths derived from the constants above
  localparam int unsigned RST_CNT_W  = $clog2(RESET_EXTEND_CYCLES + 1);
  localparam int unsigned WDOG_CNT_W = $clog2(WDOG_PERIOD_CYCLES);
  localparam int unsigned HOLD_CNT_W = $clog2(WDOG_HOLD_CYCLES + 1);

  typedef enum logic [REG_IDX_W-1:0] {
    REG_KERNEL_ARG,
    REG_COMMAND,
    REG_DATA0,
    REG_DATA1,
    REG_DELAY,
    REG_WDOG_CLEAR,
    REG_WDOG_ENABLE,
    REG_SPARE
  } reg_idx_e;

  typedef logic [WORD_W-1:0] word_t;

  // Master to slave
  typedef struct packed {
    word_t awaddr;
    logic  awvalid;
    word_t wdata;
    logic  wvalid;
    logic  bready;
    word_t araddr;
    logic  arvalid;
    logic  rready;
  } axil_req_t;

  // Slave to master, responses are always OKAY
  typedef struct packed {
    logic  awready;
    logic  wready;
    logic  bvalid;
    logic  arready;
    logic  rvalid;
    word_t rdata;
  } axil_rsp_t;

  typedef struct packed {
    word_t state0;
    word_t state1;
    word_t state2;
    word_t state3;
  } core_state_t;

  typedef struct packed {
    logic  valid;
    word_t command;
    word_t data0;
    word_t data1;
  } launch_t;

endpackage

`default_nettype wire
